/* logic/corePkg.sv */
package corePkg;

    // major opcode field in bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        opOp      = 7'b0110011,
        opOpImm   = 7'b0010011,
        opLui     = 7'b0110111,
        opAuipc   = 7'b0010111,
        opIllegal = 7'b0000000
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10   // LUI result is the immediate as is
    } aluOpT;

    typedef enum logic [1:0] {bReg, bImm, bShamt} bSelT;
    typedef enum logic [1:0] {aReg, aPc, aZero} aSelT;

    // word accepted by intake with a one-cycle valid
    typedef struct packed {
        logic        valid;
        logic [31:0] word;
        logic [31:0] pc;
    } fetchedT;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] immediate;
        logic [4:0]  shamt;
        aluOpT       aluOp;
        aSelT        aSel;
        bSelT        bSel;
        logic        writeEn;
        logic [31:0] pc;
    } decodedT;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic [4:0]  rd;
        logic [31:0] operandA;
        logic [31:0] operandB;
        aluOpT       aluOp;
        logic        writeEn;
        logic [31:0] pc;
    } issuedT;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic [4:0]  rd;
        logic [31:0] result;
        logic        wrote;   // register file was actually updated
        logic [31:0] pc;
    } commitT;

endpackage

/* logic/instrIntake.sv */
module instrIntake (
    input  logic             clk,
    input  logic             nrst,
    input  logic             req,
    input  logic [31:0]      instr,
    output logic             ack,
    input  logic             retire,
    output corePkg::fetchedT fetched
);

    // idle waits for req, busy waits for commit, done waits for req to drop
    typedef enum logic [1:0] {idle, busy, done} stateT;

    stateT       state;
    logic [31:0] pcCount;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            state   <= idle;
            ack     <= 1'b0;
            pcCount <= 32'd0;
            fetched <= '0;
        end
        else
        begin
            fetched.valid <= 1'b0;   // single cycle pulse
            case (state)
                idle:
                    if (req)
                    begin
                        fetched.valid <= 1'b1;
                        fetched.word  <= instr;
                        fetched.pc    <= pcCount;
                        pcCount       <= pcCount + 32'd4;
                        state         <= busy;
                    end
                busy:
                    if (retire)
                    begin
                        ack   <= 1'b1;   // instruction has left the pipe
                        state <= done;
                    end
                done:
                    if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= idle;
                    end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* logic/decodeStage.sv */
module decodeStage #(
    parameter int numRegs = 32
) (
    input  logic             clk,
    input  logic             nrst,
    input  corePkg::fetchedT fetched,
    output corePkg::decodedT decoded
);
    import corePkg::*;

    logic [31:0] word;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] immI;
    logic [31:0] immU;
    opcodeT      opKind;
    logic        badFunct;   // funct3/funct7 pair not defined
    logic        badIndex;   // register index beyond the implemented file
    decodedT     decodeNext;

    assign word   = fetched.word;
    assign funct3 = word[14:12];
    assign funct7 = word[31:25];
    assign immI   = {{20{word[31]}}, word[31:20]};
    assign immU   = {word[31:12], 12'b0};

    always_comb
    begin
        case (word[6:0])
            opOp:    opKind = opOp;
            opOpImm: opKind = opOpImm;
            opLui:   opKind = opLui;
            opAuipc: opKind = opAuipc;
            default: opKind = opIllegal;   // loads, stores, branches and the rest
        endcase
    end

    always_comb
    begin
        decodeNext           = '0;
        decodeNext.valid     = fetched.valid;
        decodeNext.rs1       = word[19:15];
        decodeNext.rs2       = word[24:20];
        decodeNext.rd        = word[11:7];
        decodeNext.shamt     = word[24:20];
        decodeNext.immediate = immI;
        decodeNext.pc        = fetched.pc;
        decodeNext.aluOp     = aluAdd;
        decodeNext.aSel      = aReg;
        decodeNext.bSel      = bImm;
        badFunct             = 1'b0;
        badIndex             = (word[11:7] >= numRegs);
        case (opKind)
            opOp:
            begin
                decodeNext.bSel = bReg;
                badIndex = badIndex || (word[19:15] >= numRegs) || (word[24:20] >= numRegs);
                if (funct7 == 7'b0000000)
                begin
                    case (funct3)
                        3'b000:  decodeNext.aluOp = aluAdd;
                        3'b001:  decodeNext.aluOp = aluSll;
                        3'b010:  decodeNext.aluOp = aluSlt;
                        3'b011:  decodeNext.aluOp = aluSltu;
                        3'b100:  decodeNext.aluOp = aluXor;
                        3'b101:  decodeNext.aluOp = aluSrl;
                        3'b110:  decodeNext.aluOp = aluOr;
                        default: decodeNext.aluOp = aluAnd;
                    endcase
                end
                else if (funct7 == 7'b0100000 && funct3 == 3'b000)
                    decodeNext.aluOp = aluSub;
                else if (funct7 == 7'b0100000 && funct3 == 3'b101)
                    decodeNext.aluOp = aluSra;
                else
                    badFunct = 1'b1;
            end
            opOpImm:
            begin
                badIndex = badIndex || (word[19:15] >= numRegs);
                case (funct3)
                    3'b000:  decodeNext.aluOp = aluAdd;
                    3'b010:  decodeNext.aluOp = aluSlt;
                    3'b011:  decodeNext.aluOp = aluSltu;
                    3'b100:  decodeNext.aluOp = aluXor;
                    3'b110:  decodeNext.aluOp = aluOr;
                    3'b111:  decodeNext.aluOp = aluAnd;
                    3'b001:
                    begin
                        decodeNext.aluOp = aluSll;
                        decodeNext.bSel  = bShamt;
                        badFunct = (funct7 != 7'b0000000);
                    end
                    default:   // srli / srai share funct3 101
                    begin
                        decodeNext.bSel = bShamt;
                        if (funct7 == 7'b0000000)
                            decodeNext.aluOp = aluSrl;
                        else if (funct7 == 7'b0100000)
                            decodeNext.aluOp = aluSra;
                        else
                            badFunct = 1'b1;
                    end
                endcase
            end
            opLui:
            begin
                decodeNext.immediate = immU;
                decodeNext.aSel      = aZero;
                decodeNext.aluOp     = aluPassB;
            end
            opAuipc:
            begin
                decodeNext.immediate = immU;
                decodeNext.aSel      = aPc;
            end
            default: ;
        endcase
        decodeNext.illegal = (opKind == opIllegal) || badFunct || badIndex;
        decodeNext.writeEn = !decodeNext.illegal;   // illegal ones retire silently
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            decoded <= '0;
        else
            decoded <= decodeNext;
    end

endmodule

/* logic/regFile.sv */
module regFile #(
    parameter int numRegs = 32
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        writeEn,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    input  logic [4:0]  readAddrA,
    input  logic [4:0]  readAddrB,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB
);

    logic [31:0] regs [numRegs];

    // x0 and unimplemented indices read back as zero
    assign readDataA = (readAddrA == 5'd0 || readAddrA >= numRegs) ? 32'd0 : regs[readAddrA];
    assign readDataB = (readAddrB == 5'd0 || readAddrB >= numRegs) ? 32'd0 : regs[readAddrB];

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < numRegs; i++)
                regs[i] <= 32'd0;
        end
        else if (writeEn && writeAddr != 5'd0 && writeAddr < numRegs)
        begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

/* logic/issueStage.sv */
module issueStage (
    input  logic             clk,
    input  logic             nrst,
    input  corePkg::decodedT decoded,
    output logic [4:0]       readAddrA,
    output logic [4:0]       readAddrB,
    input  logic [31:0]      readDataA,
    input  logic [31:0]      readDataB,
    output corePkg::issuedT  issued
);
    import corePkg::*;

    logic [31:0] operandA;
    logic [31:0] operandB;

    // register file is read straight from the decode register
    assign readAddrA = decoded.rs1;
    assign readAddrB = decoded.rs2;

    always_comb
    begin
        case (decoded.aSel)
            aPc:     operandA = decoded.pc;   // auipc
            aZero:   operandA = 32'd0;        // lui
            default: operandA = readDataA;
        endcase
    end

    always_comb
    begin
        case (decoded.bSel)
            bImm:    operandB = decoded.immediate;
            bShamt:  operandB = {27'd0, decoded.shamt};
            default: operandB = readDataB;
        endcase
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            issued <= '0;
        end
        else
        begin
            issued.valid    <= decoded.valid;
            issued.illegal  <= decoded.illegal;
            issued.rd       <= decoded.rd;
            issued.operandA <= operandA;
            issued.operandB <= operandB;
            issued.aluOp    <= decoded.aluOp;
            issued.writeEn  <= decoded.writeEn;
            issued.pc       <= decoded.pc;
        end
    end

endmodule

/* logic/executeStage.sv */
module executeStage (
    input  logic            clk,
    input  logic            nrst,
    input  corePkg::issuedT issued,
    output logic            writeEn,
    output logic [4:0]      writeAddr,
    output logic [31:0]     writeData,
    output corePkg::commitT commit
);
    import corePkg::*;

    logic [31:0] opA;
    logic [31:0] opB;
    logic [4:0]  shiftAmount;
    logic [31:0] aluResult;
    logic        writeNow;

    assign opA         = issued.operandA;
    assign opB         = issued.operandB;
    assign shiftAmount = opB[4:0];   // only the low five bits count

    always_comb
    begin
        case (issued.aluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluSll:   aluResult = opA << shiftAmount;
            aluSlt:   aluResult = {31'd0, ($signed(opA) < $signed(opB))};
            aluSltu:  aluResult = {31'd0, (opA < opB)};
            aluXor:   aluResult = opA ^ opB;
            aluSrl:   aluResult = opA >> shiftAmount;
            aluSra:   aluResult = $signed(opA) >>> shiftAmount;
            aluOr:    aluResult = opA | opB;
            aluAnd:   aluResult = opA & opB;
            aluPassB: aluResult = opB;
            default:  aluResult = 32'd0;
        endcase
    end

    // x0 is never written, so it is not reported as a write either
    assign writeNow = issued.valid && issued.writeEn && (issued.rd != 5'd0);

    // the register file takes the result on the same edge as the commit register
    assign writeEn   = writeNow;
    assign writeAddr = issued.rd;
    assign writeData = aluResult;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            commit <= '0;
        end
        else
        begin
            commit.valid   <= issued.valid;   // one cycle since nothing can stall it
            commit.illegal <= issued.illegal;
            commit.rd      <= issued.rd;
            commit.result  <= aluResult;
            commit.wrote   <= writeNow;
            commit.pc      <= issued.pc;
        end
    end

endmodule

/* logic/aluCore.sv */
module aluCore #(
    parameter int numRegs = 32   // 16 for the E variant
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic            req,
    input  logic [31:0]     instr,
    output logic            ack,
    output corePkg::commitT commit
);
    import corePkg::*;

    fetchedT     fetched;
    decodedT     decoded;
    issuedT      issued;
    logic [4:0]  readAddrA;
    logic [4:0]  readAddrB;
    logic [31:0] readDataA;
    logic [31:0] readDataB;
    logic        writeEn;
    logic [4:0]  writeAddr;
    logic [31:0] writeData;

    instrIntake intake (
        .clk(clk), .nrst(nrst), .req(req), .instr(instr), .ack(ack),
        .retire(commit.valid),   // ack waits for the commit pulse
        .fetched(fetched)
    );

    decodeStage #(.numRegs(numRegs)) decode (
        .clk(clk), .nrst(nrst), .fetched(fetched), .decoded(decoded)
    );

    issueStage issue (
        .clk(clk), .nrst(nrst), .decoded(decoded),
        .readAddrA(readAddrA), .readAddrB(readAddrB),
        .readDataA(readDataA), .readDataB(readDataB), .issued(issued)
    );

    regFile #(.numRegs(numRegs)) regs (
        .clk(clk), .nrst(nrst), .writeEn(writeEn), .writeAddr(writeAddr),
        .writeData(writeData), .readAddrA(readAddrA), .readAddrB(readAddrB),
        .readDataA(readDataA), .readDataB(readDataB)
    );

    executeStage execute (
        .clk(clk), .nrst(nrst), .issued(issued), .writeEn(writeEn),
        .writeAddr(writeAddr), .writeData(writeData), .commit(commit)
    );

endmodule

/* dv/intake_properties.sv */
module intakeProperties (
    input logic             clk,
    input logic             nrst,
    input logic             req,
    input logic [31:0]      instr,
    input logic             ack,
    input corePkg::fetchedT fetched
);

    // ack is raised by an edge that still saw req high
    ackRisesWithReq: assert property (@(posedge clk) disable iff (!nrst)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // the source may not change the word before it is acknowledged
    instrHeld: assert property (@(posedge clk) disable iff (!nrst)
        req && $past(req) && !$past(ack) |-> $stable(instr))
        else $error("instr changed while req was high and ack low");

    ackFallsAfterReq: assert property (@(posedge clk) disable iff (!nrst)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    fetchPulse: assert property (@(posedge clk) disable iff (!nrst)
        fetched.valid |=> !fetched.valid)   // handed to decode once
        else $error("fetched valid lasted more than one cycle");

endmodule

bind instrIntake intakeProperties props (
    .clk(clk), .nrst(nrst), .req(req), .instr(instr), .ack(ack), .fetched(fetched)
);

/* dv/aluCoreTb.sv */
module aluCoreTb;
    import corePkg::*;

    typedef enum logic [4:0] {
        kAddi, kAdd, kSub, kAnd, kOr, kXor, kSlt, kSltu, kSll, kSrl, kSra,
        kSlli, kSrli, kSrai, kLui, kAuipc, kStore, kBadF7
    } kindT;

    // val is rs2 for register forms, the immediate or shamt otherwise
    typedef struct packed {
        kindT        kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [31:0] val;
        logic        illegal;
    } rowT;

    logic        clk;
    logic        nrst;
    logic        req;
    logic [31:0] instr;
    logic        ack;
    commitT      commit;

    rowT         rows [40];
    int          rowCount = 0;
    logic [31:0] modelRegs [32];
    logic [31:0] modelPc;
    int          testIndex;
    int          rowErrors;
    int          cycleCount = 0;
    int          cycleLimit = 1000;

    aluCore #(.numRegs(32)) UUT (
        .clk(clk), .nrst(nrst), .req(req), .instr(instr), .ack(ack), .commit(commit)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        forever
        begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount >= cycleLimit)
            begin
                $display("run stopped at cycle %0d, the tests did not finish in time", cycleCount);
                $display("STATUS: FAIL");
                $finish;
            end
        end
    end

    task automatic addRow(input kindT kind, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [31:0] val, input logic illegal);
        rows[rowCount] = '{kind, rd, rs1, val, illegal};
        rowCount++;
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("Fail test %0d %s got %h expected %h", testIndex, name, got, expected);
        rowErrors++;
    endtask

    function automatic logic [31:0] encode(rowT r);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = (r.kind inside {kSub, kSra, kSrai}) ? 7'h20 : 7'h00;
        if (r.kind == kBadF7)
            f7 = 7'h01;   // mul encoding
        case (r.kind)
            kSll, kSlli:               f3 = 3'b001;
            kSlt, kStore:              f3 = 3'b010;
            kSltu:                     f3 = 3'b011;
            kXor:                      f3 = 3'b100;
            kSrl, kSra, kSrli, kSrai:  f3 = 3'b101;
            kOr:                       f3 = 3'b110;
            kAnd:                      f3 = 3'b111;
            default:                   f3 = 3'b000;
        endcase
        case (r.kind)
            kAddi:               encode = {r.val[11:0], r.rs1, f3, r.rd, 7'b0010011};
            kSlli, kSrli, kSrai: encode = {f7, r.val[4:0], r.rs1, f3, r.rd, 7'b0010011};
            kLui:                encode = {r.val[31:12], r.rd, 7'b0110111};
            kAuipc:              encode = {r.val[31:12], r.rd, 7'b0010111};
            kStore:              encode = {7'h00, r.val[4:0], r.rs1, f3, r.rd, 7'b0100011};
            default:             encode = {f7, r.val[4:0], r.rs1, f3, r.rd, 7'b0110011};
        endcase
    endfunction

    // RV32I result from the model registers and the model pc
    function automatic logic [31:0] expectedResult(rowT r);
        logic [31:0] a;
        logic [31:0] b;
        a = modelRegs[r.rs1];
        b = modelRegs[r.val[4:0]];
        case (r.kind)
            kAddi:  expectedResult = a + {{20{r.val[11]}}, r.val[11:0]};
            kAdd:   expectedResult = a + b;
            kSub:   expectedResult = a - b;
            kAnd:   expectedResult = a & b;
            kOr:    expectedResult = a | b;
            kXor:   expectedResult = a ^ b;
            kSlt:   expectedResult = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            kSltu:  expectedResult = (a < b) ? 32'd1 : 32'd0;
            kSll:   expectedResult = a << b[4:0];
            kSrl:   expectedResult = a >> b[4:0];
            kSra:   expectedResult = $signed(a) >>> b[4:0];
            kSlli:  expectedResult = a << r.val[4:0];
            kSrli:  expectedResult = a >> r.val[4:0];
            kSrai:  expectedResult = $signed(a) >>> r.val[4:0];
            kLui:   expectedResult = {r.val[31:12], 12'h000};
            kAuipc: expectedResult = modelPc + {r.val[31:12], 12'h000};
            default: expectedResult = 32'd0;
        endcase
    endfunction

    // starts a few units after an edge and returns at the same point
    task automatic runTransaction(input logic [31:0] word, output commitT seen,
                                  output int commitCycle, output int ackCycle);
        int n;
        n = 0;
        commitCycle = 0;
        ackCycle = 0;
        seen = '0;
        instr = word;
        req = 1'b1;
        while (ackCycle == 0 && n < 12)
        begin
            @(posedge clk);
            #1;
            n++;   // the edge that samples req is cycle 1
            if (commit.valid && commitCycle == 0)
            begin
                seen = commit;
                commitCycle = n;
            end
            if (ack)
                ackCycle = n;
        end
        req = 1'b0;
        while (ack)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    initial
    begin
        rowT         r;
        commitT      seen;
        int          commitCycle;
        int          ackCycle;
        int          seedValue;
        int          passCount;
        int          failCount;
        logic [31:0] expRes;
        logic        expWrote;
        nrst = 1'b0;
        req = 1'b0;
        instr = 32'd0;
        passCount = 0;
        failCount = 0;
        seedValue = $urandom(50);
        addRow(kAddi, 1, 0, $urandom, 0);   // random immediate
        addRow(kAddi, 2, 0, $urandom, 0);   // random immediate
        addRow(kAddi, 3, 0, 32'hffb, 0);    // -5
        addRow(kAddi, 4, 1, $urandom, 0);   // random immediate
        addRow(kAdd, 5, 1, 2, 0);
        addRow(kSub, 6, 3, 1, 0);
        addRow(kAnd, 7, 1, 2, 0);
        addRow(kOr, 8, 2, 3, 0);
        addRow(kXor, 9, 1, 3, 0);
        addRow(kSlt, 10, 3, 1, 0);
        addRow(kSltu, 11, 3, 1, 0);
        addRow(kAddi, 12, 0, 7, 0);
        addRow(kSll, 13, 3, 12, 0);
        addRow(kSrl, 14, 3, 12, 0);
        addRow(kSra, 15, 3, 12, 0);
        addRow(kSlli, 16, 1, 5, 0);
        addRow(kSrli, 17, 3, 31, 0);
        addRow(kSrai, 18, 3, 3, 0);
        addRow(kLui, 19, 0, $urandom, 0);   // random immediate
        addRow(kAuipc, 20, 0, $urandom, 0); // random immediate
        addRow(kLui, 21, 0, 32'h80000000, 0);
        addRow(kSrai, 22, 21, 4, 0);
        addRow(kAddi, 0, 1, 1, 0);          // x0 stays zero
        addRow(kAdd, 23, 0, 4, 0);
        addRow(kStore, 5, 1, 2, 1);         // sw whose rd field names x5
        addRow(kBadF7, 6, 1, 2, 1);
        addRow(kAdd, 24, 5, 0, 0);
        addRow(kAdd, 25, 6, 0, 0);
        cycleLimit = rowCount * 12 + 50;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = 32'd0;
        modelPc = 32'd0;
        repeat (2) @(posedge clk);
        #1;
        nrst = 1'b1;
        for (int i = 0; i < rowCount; i++)
        begin
            r = rows[i];
            testIndex = i;
            rowErrors = 0;
            expRes = expectedResult(r);
            expWrote = !r.illegal && (r.rd != 5'd0);
            runTransaction(encode(r), seen, commitCycle, ackCycle);
            if (commitCycle == 0)
            begin
                $display("test %0d: no commit appeared for the instruction", i);
                rowErrors++;
            end
            else
            begin
                if (seen.illegal !== r.illegal)
                    reportMismatch("commit.illegal", seen.illegal, r.illegal);
                if (seen.rd !== r.rd)
                    reportMismatch("commit.rd", seen.rd, r.rd);
                if (seen.pc !== modelPc)
                    reportMismatch("commit.pc", seen.pc, modelPc);
                if (seen.wrote !== expWrote)
                    reportMismatch("commit.wrote", seen.wrote, expWrote);
                if (!r.illegal && seen.result !== expRes)
                    reportMismatch("commit.result", seen.result, expRes);
                if (commitCycle != 4)
                begin
                    $display("test %0d: commit came %0d cycles after req, not 4", i, commitCycle);
                    rowErrors++;
                end
            end
            if (ackCycle == 0)
            begin
                $display("test %0d: ack was never raised", i);
                rowErrors++;
            end
            else if (commitCycle != 0 && ackCycle != commitCycle + 1)
            begin
                $display("test %0d: ack did not rise the cycle after commit", i);
                rowErrors++;
            end
            if (expWrote)
                modelRegs[r.rd] = expRes;
            modelPc = modelPc + 32'd4;   // every accepted word advances the pc
            $display("test %0d %s: %s", i, r.kind.name(), rowErrors ? "failed" : "passed");
            if (rowErrors)
                failCount++;
            else
                passCount++;
        end
        $display("%0d tests, %0d passed, %0d failed", rowCount, passCount, failCount);
        if (failCount == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* tb.f */
logic/corePkg.sv
logic/instrIntake.sv
logic/decodeStage.sv
logic/regFile.sv
logic/issueStage.sv
logic/executeStage.sv
logic/aluCore.sv
dv/intake_properties.sv
dv/aluCoreTb.sv
